/* pipelineCpu.f */
cpuPkg.sv
fetchUnit.sv
regFile.sv
decodeUnit.sv
executeUnit.sv
pipelineCpu.sv
+incdir+.
tbPipelineCpu.sv

/* Makefile */
# Verilator build and run for the pipelined core

VERILATOR ?= verilator
TOP       ?= tbPipelineCpu
RTL_TOP   ?= pipelineCpu
FILELIST  ?= pipelineCpu.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
PASS_MSG  ?= All tests passed!

VFLAGS ?= --binary --timing --assert -j $(JOBS) --Mdir $(OBJ_DIR)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL" && exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tbProgram.svh */
////////////////////////////////////////////////////////////////////////////
// Testbench program helpers
// RV32I encoders for the kept instructions and a reference ALU model
////////////////////////////////////////////////////////////////////////////
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// R-type, register-register
function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd);
   return {f7, rs2, rs1, f3, rd, opCompute};
endfunction

// I-type, register-immediate
function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd);
   return {imm, rs1, f3, rd, opImmediate};
endfunction

// Shift by immediate, alt picks srai
function automatic logic [31:0] encShift(input logic alt, input logic [4:0] shamt,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
   return {(alt ? f7Alt : f7Base), shamt, rs1, f3, rd, opImmediate};
endfunction

// U-type, lui or auipc
function automatic logic [31:0] encU(input opcodeT op, input logic [19:0] imm,
                                     input logic [4:0] rd);
   return {imm, rd, op};
endfunction

// Store word, used only to stop the core
function automatic logic [31:0] encStore(input logic [4:0] rs2, input logic [4:0] rs1,
                                         input logic [11:0] imm);
   return {imm[11:5], rs2, rs1, f3Sw, imm[4:0], opStore};
endfunction

// Reference ALU, straight from the RV32I rules per funct3
function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic alt,
                                       input logic [31:0] a, input logic [31:0] b);
   logic [31:0] res;
   case (f3)
      3'b000:  res = alt ? a - b : a + b;
      3'b001:  res = a << b[4:0];
      3'b010:  res = {31'b0, $signed(a) < $signed(b)};
      3'b011:  res = {31'b0, a < b};
      3'b100:  res = a ^ b;
      3'b101:  res = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  res = a | b;
      default: res = a & b;
   endcase
   return res;
endfunction

`endif

/* tbPipelineCpu.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the pipelined RV32I core
// Random program with shadow register model, checked by assertions
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module tbPipelineCpu;
   import cpuPkg::*;
   `include "tbProgram.svh"

   localparam logic [31:0] resetPc  = 32'h0000_0100;   // Word-aligned start address
   localparam int          memWords = 512;

   logic        clk;
   logic        rstN;
   logic [31:0] instAddr;
   logic [31:0] instWord;
   logic        wbEn;
   logic [4:0]  wbRd;
   logic [31:0] wbData;
   logic        halt;

   // Program and per-word expectations
   logic [31:0] imem [memWords];
   logic        expWr [memWords];
   logic [4:0]  expRd [memWords];
   logic [31:0] expData [memWords];
   logic [31:0] shadow [32];                           // Reference registers
   logic [4:0]  qRd [$];                               // Writes still to come
   logic [31:0] qData [$];
   int          progLen = 0;
   int          haltIdx = 0;
   int          errCount = 0;
   int          cycleCount = 0;
   int          cycleLimit = memWords + 100;

   // Delay lines and history
   logic        v1 = 0;                                // Address was post-reset
   logic        v2 = 0;
   logic        v3 = 0;
   logic [31:0] expAddr;                               // Fetch address the core should show
   logic [31:0] addrD1 = '0;
   logic [31:0] addrD2 = '0;
   logic [31:0] addrD3 = '0;
   int          rstCount = 0;

   logic        expWrNow;
   logic [4:0]  expRdNow;
   logic [31:0] expDataNow;
   logic        expHalt;

   pipelineCpu #(.resetPc(resetPc)) uut (
      .clk, .rstN, .instAddr, .instWord, .wbEn, .wbRd, .wbData, .halt
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Combinational instruction memory
   always_comb begin
      int idx;
      idx = int'((instAddr - resetPc) >> 2);
      if (instAddr >= resetPc && idx < progLen) begin
         instWord = imem[idx];
      end else begin
         instWord = nopWord;                            // Outside the program
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Program generation
   ////////////////////////////////////////////////////////////////////////////
   task automatic addWord(input logic [31:0] word, input logic wr, input logic [4:0] rd,
                          input logic [31:0] data);
      imem[progLen]    = word;
      expWr[progLen]   = wr && (rd != 5'd0);            // x0 never strobes
      expRd[progLen]   = rd;
      expData[progLen] = data;
      progLen++;
   endtask

   // One instruction, two nops for the spacing rule
   task automatic issue(input logic [31:0] word, input logic [4:0] rd,
                        input logic [31:0] data);
      addWord(word, 1'b1, rd, data);
      if (rd != 5'd0) begin
         shadow[rd] = data;
         qRd.push_back(rd);
         qData.push_back(data);
      end
      addWord(nopWord, 1'b0, 5'd0, '0);
      addWord(nopWord, 1'b0, 5'd0, '0);
   endtask

   task automatic doR(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                      input logic [4:0] rs1, input logic [4:0] rs2);
      issue(encR(alt ? f7Alt : f7Base, rs2, rs1, f3, rd), rd,
            refAlu(f3, alt, shadow[rs1], shadow[rs2]));
   endtask

   task automatic doI(input logic [2:0] f3, input logic [11:0] imm, input logic [4:0] rd,
                      input logic [4:0] rs1);
      issue(encI(imm, rs1, f3, rd), rd,
            refAlu(f3, 1'b0, shadow[rs1], {{20{imm[11]}}, imm}));
   endtask

   task automatic doShift(input logic [2:0] f3, input logic alt, input logic [4:0] shamt,
                          input logic [4:0] rd, input logic [4:0] rs1);
      issue(encShift(alt, shamt, rs1, f3, rd), rd,
            refAlu(f3, alt, shadow[rs1], {27'b0, shamt}));
   endtask

   task automatic doUpper(input opcodeT op, input logic [19:0] imm, input logic [4:0] rd);
      logic [31:0] pc;
      pc = resetPc + 32'(progLen * 4);                  // Address of this word
      issue(encU(op, imm, rd), rd, (op == opAddUpper ? pc : 32'd0) + {imm, 12'b0});
   endtask

   // lui plus addi, upper part rounded for the sign of the low part
   task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
      doUpper(opLoadUpper, value[31:12] + 20'(value[11]), rd);
      doI(3'b000, value[11:0], rd, rd);
   endtask

   function automatic logic [4:0] destReg();
      return 5'(10 + ($urandom % 22));                  // x10 to x31
   endfunction

   function automatic logic [4:0] srcReg();
      return 5'(1 + ($urandom % 31));
   endfunction

   task automatic buildProgram();
      logic [2:0] iOps [6];
      logic [11:0] imm;
      iOps = '{3'b000, 3'b010, 3'b011, 3'b100, 3'b110, 3'b111};
      for (int i = 0; i < memWords; i++) expWr[i] = 1'b0;
      for (int i = 0; i < 32; i++) shadow[i] = '0;
      for (int r = 1; r <= 6; r++) loadConst(5'(r), $urandom());
      loadConst(5'd7, 32'h8000_0000 | ($urandom() & 32'hff));   // Big negative
      for (int round = 0; round < 3; round++) begin
         for (int f3 = 0; f3 < 8; f3++) doR(3'(f3), 1'b0, destReg(), srcReg(), srcReg());
         doR(3'b000, 1'b1, destReg(), srcReg(), srcReg());      // sub
         doR(3'b101, 1'b1, destReg(), srcReg(), srcReg());      // sra
         for (int k = 0; k < 6; k++) begin
            imm = 12'($urandom());
            if (k[0] == 1'b0) imm[11] = 1'b1;                   // Negative half
            doI(iOps[k], imm, destReg(), srcReg());
         end
         doShift(3'b001, 1'b0, 5'($urandom()), destReg(), srcReg());
         doShift(3'b101, 1'b0, 5'($urandom()), destReg(), srcReg());
         doShift(3'b101, 1'b1, 5'($urandom()), destReg(), 5'd7);
      end
      for (int k = 0; k < 4; k++) begin
         doUpper(opLoadUpper, 20'($urandom()), destReg());
         doUpper(opAddUpper, 20'($urandom()), destReg());
      end
      doR(3'b000, 1'b0, 5'd0, 5'd1, 5'd2);               // Write to x0, no strobe
      doI(3'b000, 12'h123, 5'd9, 5'd0);                  // x0 must still read zero
      haltIdx = progLen;
      addWord(encStore(5'd2, 5'd1, 12'h010), 1'b0, 5'd0, '0);
      addWord(encI(12'h055, 5'd0, 3'b000, 5'd8), 1'b0, 5'd0, '0);  // Younger, no write
      addWord(encU(opLoadUpper, 20'h12345, 5'd11), 1'b0, 5'd0, '0);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Reference timing and checks
   ////////////////////////////////////////////////////////////////////////////
   always @(posedge clk) begin
      v1     <= rstN;
      v2     <= v1;
      v3     <= v2;
      addrD1 <= expAddr;
      addrD2 <= addrD1;
      addrD3 <= addrD2;
      if (!rstN) begin
         expAddr  <= resetPc;
         rstCount <= rstCount + 1;
      end else if (!expHalt) begin
         expAddr  <= expAddr + 32'd4;                    // Frozen once the store is in decode
      end
   end

   // Expected write-back for the word fetched three cycles ago
   always_comb begin
      int idx;
      idx        = int'((addrD3 - resetPc) >> 2);
      expWrNow   = 1'b0;
      expRdNow   = '0;
      expDataNow = '0;
      if (v3 && addrD3 >= resetPc && idx < progLen) begin
         expWrNow   = expWr[idx];
         expRdNow   = expRd[idx];
         expDataNow = expData[idx];
      end
      expHalt = v2 && (addrD2 >= resetPc + 32'(haltIdx * 4));   // Store reached decode
   end

   assert property (@(posedge clk) (!rstN && rstCount >= 1) |->
                    (instAddr == resetPc && !wbEn && !halt))
      else begin
         errCount++;
         $display("ERR reset instAddr exp %h got %h wbEn %h halt %h",
                  resetPc, instAddr, wbEn, halt);
      end

   assert property (@(posedge clk) disable iff (!rstN) instAddr == expAddr)
      else begin
         errCount++;
         $display("ERR instAddr exp %h got %h", expAddr, instAddr);
      end

   // Covers timing, x0 writes and the silence after halt
   assert property (@(posedge clk) disable iff (!rstN) wbEn == expWrNow)
      else begin
         errCount++;
         $display("ERR wbEn exp %h got %h", expWrNow, wbEn);
      end

   assert property (@(posedge clk) disable iff (!rstN) (wbEn && expWrNow) |->
                    wbRd == expRdNow)
      else begin
         errCount++;
         $display("ERR wbRd exp %h got %h", expRdNow, wbRd);
      end

   assert property (@(posedge clk) disable iff (!rstN) (wbEn && expWrNow) |->
                    wbData == expDataNow)
      else begin
         errCount++;
         $display("ERR wbData exp %h got %h", expDataNow, wbData);
      end

   assert property (@(posedge clk) disable iff (!rstN) halt == expHalt)
      else begin
         errCount++;
         $display("ERR halt exp %h got %h", expHalt, halt);
      end

   // Retire expected writes in order
   always @(posedge clk) begin
      if (rstN && wbEn) begin
         if (qRd.size() == 0) begin
            errCount++;
            $display("Write-back seen with no expected write left");
         end else begin
            assert (wbRd == qRd[0])
               else begin
                  errCount++;
                  $display("ERR wbRd queue exp %h got %h", qRd[0], wbRd);
               end
            assert (wbData == qData[0])
               else begin
                  errCount++;
                  $display("ERR wbData queue exp %h got %h", qData[0], wbData);
               end
            void'(qRd.pop_front());
            void'(qData.pop_front());
         end
      end
   end

   // Watchdog
   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= cycleLimit) begin
         $display("Timeout after %0d cycles, the core never halted", cycleCount);
         $display("Test failures found");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      rstN = 1'b0;
      void'($urandom(53));
      buildProgram();
      cycleLimit = progLen + 20 + 3;                    // Program plus drain and reset
      repeat (3) @(posedge clk);
      rstN <= 1'b1;
      while (!halt) @(posedge clk);
      repeat (6) @(posedge clk);                        // Let the pipe drain
      if (qRd.size() != 0) begin
         errCount++;
         $display("%0d expected writes never appeared", qRd.size());
      end
      $display("Errors: %0d", errCount);
      if (errCount == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

/* pipelineCpu.sv */
////////////////////////////////////////////////////////////////////////////
// RV32I integer core, fetch, decode and execute stages plus write-back
// Three instructions in flight, no forwarding and no stalls
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module pipelineCpu #(
   parameter logic [cpuPkg::xlen-1:0] resetPc = '0
) (
   input  logic                        clk,
   input  logic                        rstN,
   output logic [cpuPkg::xlen-1:0]     instAddr,   // Instruction port
   input  logic [cpuPkg::xlen-1:0]     instWord,
   output logic                        wbEn,       // Write-back port
   output logic [cpuPkg::regAddrW-1:0] wbRd,
   output logic [cpuPkg::xlen-1:0]     wbData,
   output logic                        halt
);
   import cpuPkg::*;

   // Fetch to decode
   logic [xlen-1:0]     fetchWord;
   logic [xlen-1:0]     fetchPc;

   // Register file read side
   logic [regAddrW-1:0] rdAddrA;
   logic [regAddrW-1:0] rdAddrB;
   logic [xlen-1:0]     rdDataA;
   logic [xlen-1:0]     rdDataB;

   // Decode to execute
   aluOpT               exAluOp;
   srcAT                exSrcA;
   srcBT                exSrcB;
   logic [xlen-1:0]     exRs1Data;
   logic [xlen-1:0]     exRs2Data;
   logic [xlen-1:0]     exImm;
   logic [xlen-1:0]     exPc;
   logic [regAddrW-1:0] exRd;
   logic                exWrEn;

   fetchUnit #(.resetPc(resetPc)) fetch (
      .clk, .rstN, .halt, .instWord, .instAddr, .fetchWord, .fetchPc
   );

   decodeUnit decode (
      .clk, .rstN, .fetchWord, .fetchPc,
      .rdAddrA, .rdAddrB, .rdDataA, .rdDataB,
      .exAluOp, .exSrcA, .exSrcB, .exRs1Data, .exRs2Data,
      .exImm, .exPc, .exRd, .exWrEn, .halt
   );

   regFile regs (
      .clk, .rstN, .rdAddrA, .rdAddrB, .rdDataA, .rdDataB,
      .wrEn(wbEn), .wrAddr(wbRd), .wrData(wbData)    // Write-back closes the loop
   );

   executeUnit execute (
      .clk, .rstN, .exAluOp, .exSrcA, .exSrcB, .exRs1Data, .exRs2Data,
      .exImm, .exPc, .exRd, .exWrEn, .wbEn, .wbRd, .wbData
   );

endmodule

/* executeUnit.sv */
////////////////////////////////////////////////////////////////////////////
// Execute stage
// Operand select, ALU and the execute/write-back register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module executeUnit (
   input  logic                        clk,
   input  logic                        rstN,
   input  cpuPkg::aluOpT               exAluOp,
   input  cpuPkg::srcAT                exSrcA,
   input  cpuPkg::srcBT                exSrcB,
   input  logic [cpuPkg::xlen-1:0]     exRs1Data,
   input  logic [cpuPkg::xlen-1:0]     exRs2Data,
   input  logic [cpuPkg::xlen-1:0]     exImm,
   input  logic [cpuPkg::xlen-1:0]     exPc,
   input  logic [cpuPkg::regAddrW-1:0] exRd,
   input  logic                        exWrEn,
   output logic                        wbEn,       // Register file write strobe
   output logic [cpuPkg::regAddrW-1:0] wbRd,
   output logic [cpuPkg::xlen-1:0]     wbData
);
   import cpuPkg::*;

   logic [xlen-1:0] opA;
   logic [xlen-1:0] opB;
   logic [4:0]      shamt;                         // Low five bits of operand B
   logic [xlen-1:0] aluResult;

   ////////////////////////////////////////////////////////////////////////////
   // Operand select
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      case (exSrcA)
         srcARs1: opA = exRs1Data;
         srcAPc:  opA = exPc;                      // auipc
         default: opA = '0;                        // lui
      endcase
   end

   assign opB   = (exSrcB == srcBImm) ? exImm : exRs2Data;
   assign shamt = opB[4:0];

   ////////////////////////////////////////////////////////////////////////////
   // ALU
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      case (exAluOp)
         aluAdd:  aluResult = opA + opB;
         aluSub:  aluResult = opA - opB;
         aluSll:  aluResult = opA << shamt;
         aluSlt:  aluResult = xlen'($signed(opA) < $signed(opB));
         aluSltu: aluResult = xlen'(opA < opB);
         aluXor:  aluResult = opA ^ opB;
         aluSrl:  aluResult = opA >> shamt;
         aluSra:  aluResult = $unsigned($signed(opA) >>> shamt);
         aluOr:   aluResult = opA | opB;
         aluAnd:  aluResult = opA & opB;
         default: aluResult = '0;
      endcase
   end

   // Execute/write-back register, strobe part
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         wbEn <= 1'b0;
      end else begin
         wbEn <= exWrEn && (exRd != '0);           // No strobe for x0
      end
   end

   // Result and destination
   always_ff @(posedge clk) begin
      wbRd   <= exRd;
      wbData <= aluResult;
   end

endmodule

/* decodeUnit.sv */
////////////////////////////////////////////////////////////////////////////
// Decode stage
// Field split, immediates, control decode, halt detection and the
// decode/execute register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module decodeUnit (
   input  logic                        clk,
   input  logic                        rstN,
   input  logic [cpuPkg::xlen-1:0]     fetchWord,
   input  logic [cpuPkg::xlen-1:0]     fetchPc,
   output logic [cpuPkg::regAddrW-1:0] rdAddrA,    // rs1 index
   output logic [cpuPkg::regAddrW-1:0] rdAddrB,    // rs2 index
   input  logic [cpuPkg::xlen-1:0]     rdDataA,
   input  logic [cpuPkg::xlen-1:0]     rdDataB,
   output cpuPkg::aluOpT               exAluOp,
   output cpuPkg::srcAT                exSrcA,
   output cpuPkg::srcBT                exSrcB,
   output logic [cpuPkg::xlen-1:0]     exRs1Data,
   output logic [cpuPkg::xlen-1:0]     exRs2Data,
   output logic [cpuPkg::xlen-1:0]     exImm,
   output logic [cpuPkg::xlen-1:0]     exPc,
   output logic [cpuPkg::regAddrW-1:0] exRd,
   output logic                        exWrEn,     // Write strobe, low for bubbles
   output logic                        halt        // Sticky
);
   import cpuPkg::*;

   // Instruction fields
   opcodeT               opcode;
   logic [regAddrW-1:0]  rd;
   logic [2:0]           funct3;
   logic [6:0]           funct7;
   logic [xlen-1:0]      immI;                     // Sign-extended I immediate
   logic [xlen-1:0]      immU;                     // Upper immediate

   // Decoded control
   aluOpT                decAluOp;
   srcAT                 decSrcA;
   srcBT                 decSrcB;
   logic [xlen-1:0]      decImm;
   logic                 decWrEn;
   logic                 legal;                    // Opcode executed by this core

   assign opcode  = opcodeT'(fetchWord[6:0]);
   assign rd      = fetchWord[11:7];
   assign funct3  = fetchWord[14:12];
   assign rdAddrA = fetchWord[19:15];
   assign rdAddrB = fetchWord[24:20];
   assign funct7  = fetchWord[31:25];

   assign immI = {{(xlen-12){fetchWord[31]}}, fetchWord[31:20]};
   assign immU = {fetchWord[31:12], 12'b0};

   // Shared funct3 map, alt picks sub or sra
   function automatic aluOpT aluDecode(input logic [2:0] f3, input logic alt);
      case (f3)
         f3AddSub: return alt ? aluSub : aluAdd;
         f3Sll:    return aluSll;
         f3Slt:    return aluSlt;
         f3Sltu:   return aluSltu;
         f3Xor:    return aluXor;
         f3SrlSra: return alt ? aluSra : aluSrl;
         f3Or:     return aluOr;
         default:  return aluAnd;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Control decode
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      decAluOp = aluAdd;
      decSrcA  = srcARs1;
      decSrcB  = srcBRs2;
      decImm   = immI;
      decWrEn  = 1'b0;
      legal    = 1'b1;
      case (opcode)
         opCompute: begin
            decAluOp = aluDecode(funct3, funct7 == f7Alt);
            decWrEn  = 1'b1;
         end
         opImmediate: begin
            // Only the shift uses bit 30, addi never turns into sub
            decAluOp = aluDecode(funct3, (funct3 == f3SrlSra) && fetchWord[30]);
            decSrcB  = srcBImm;
            decWrEn  = 1'b1;
         end
         opLoadUpper: begin
            decSrcA  = srcAZero;                   // 0 + immU
            decSrcB  = srcBImm;
            decImm   = immU;
            decWrEn  = 1'b1;
         end
         opAddUpper: begin
            decSrcA  = srcAPc;                     // pc + immU
            decSrcB  = srcBImm;
            decImm   = immU;
            decWrEn  = 1'b1;
         end
         default: legal = 1'b0;                    // Loads, stores, jumps, branches
      endcase
   end

   // Halt flag
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         halt <= 1'b0;
      end else if (!legal) begin
         halt <= 1'b1;
      end
   end

   // Decode/execute register, strobe part
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         exWrEn <= 1'b0;
      end else begin
         exWrEn <= decWrEn && !halt;               // Younger than halt become bubbles
      end
   end

   // Decode/execute register, payload
   always_ff @(posedge clk) begin
      exAluOp   <= decAluOp;
      exSrcA    <= decSrcA;
      exSrcB    <= decSrcB;
      exRs1Data <= rdDataA;
      exRs2Data <= rdDataB;
      exImm     <= decImm;
      exPc      <= fetchPc;
      exRd      <= rd;
   end

   // Nothing reaches execute with a write once halted
   assert property (@(posedge clk) disable iff (!rstN) halt |-> !exWrEn)
      else $error("decodeUnit write strobe while halted");

endmodule

/* regFile.sv */
////////////////////////////////////////////////////////////////////////////
// Register file
// 32 x xlen, two read ports, one write port with write-through, x0 is zero
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module regFile (
   input  logic                        clk,
   input  logic                        rstN,
   input  logic [cpuPkg::regAddrW-1:0] rdAddrA,
   input  logic [cpuPkg::regAddrW-1:0] rdAddrB,
   output logic [cpuPkg::xlen-1:0]     rdDataA,
   output logic [cpuPkg::xlen-1:0]     rdDataB,
   input  logic                        wrEn,
   input  logic [cpuPkg::regAddrW-1:0] wrAddr,
   input  logic [cpuPkg::xlen-1:0]     wrData
);
   import cpuPkg::*;

   localparam int numRegs = 1 << regAddrW;

   logic [xlen-1:0] regs [numRegs];
   logic            wrLive;                           // Write that really lands

   assign wrLive = wrEn && (wrAddr != '0);            // x0 never written

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wrLive) begin
         regs[wrAddr] <= wrData;
      end
   end

   // Write-through so decode sees a same-cycle write-back
   assign rdDataA = (wrLive && (wrAddr == rdAddrA)) ? wrData : regs[rdAddrA];
   assign rdDataB = (wrLive && (wrAddr == rdAddrB)) ? wrData : regs[rdAddrB];

   // x0 reads zero even with a write to x0 in flight
   assert property (@(posedge clk) disable iff (!rstN)
                    ((rdAddrA == '0) |-> (rdDataA == '0)) and
                    ((rdAddrB == '0) |-> (rdDataB == '0)))
      else $error("regFile x0 read returned nonzero");

endmodule

/* fetchUnit.sv */
////////////////////////////////////////////////////////////////////////////
// Fetch stage
// Program counter and fetch/decode register, frozen once halt is set
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module fetchUnit #(
   parameter logic [cpuPkg::xlen-1:0] resetPc = '0   // First fetch address
) (
   input  logic                    clk,
   input  logic                    rstN,
   input  logic                    halt,              // Sticky stop from decode
   input  logic [cpuPkg::xlen-1:0] instWord,          // Word at instAddr, same cycle
   output logic [cpuPkg::xlen-1:0] instAddr,
   output logic [cpuPkg::xlen-1:0] fetchWord,         // To decode
   output logic [cpuPkg::xlen-1:0] fetchPc            // PC of fetchWord
);
   import cpuPkg::*;

   logic [xlen-1:0] pc;

   assign instAddr = pc;                              // Combinational memory port

   // PC and instruction word
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc        <= resetPc;
         fetchWord <= nopWord;                        // Start with a bubble
      end else if (halt) begin
         fetchWord <= nopWord;                        // PC holds, bubbles only
      end else begin
         pc        <= pc + xlen'(4);
         fetchWord <= instWord;
      end
   end

   // PC travels along with the word
   always_ff @(posedge clk) begin
      fetchPc <= pc;
   end

   // Once halted the fetch address never moves again
   assert property (@(posedge clk) disable iff (!rstN) halt |=> $stable(instAddr))
      else $error("fetchUnit instAddr moved while halted");

endmodule

/* cpuPkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared definitions for the RV32I pipelined core
// Widths, major opcodes, ALU operations, operand selects and field codes
////////////////////////////////////////////////////////////////////////////
package cpuPkg;

   localparam int xlen     = 32;                  // Data and address width
   localparam int regAddrW = 5;                   // Register index width

   // Major opcodes, instruction bits 6:0
   typedef enum logic [6:0] {
      opCompute   = 7'b0110011,                   // R-type ALU
      opImmediate = 7'b0010011,                   // I-type ALU
      opLoad      = 7'b0000011,                   // Not executed, halts
      opStore     = 7'b0100011,                   // Not executed, halts
      opBranch    = 7'b1100011,                   // Not executed, halts
      opJump      = 7'b1101111,                   // jal, halts
      opJumpReg   = 7'b1100111,                   // jalr, halts
      opLoadUpper = 7'b0110111,                   // lui
      opAddUpper  = 7'b0010111                    // auipc
   } opcodeT;

   typedef enum logic [3:0] {
      aluAdd,
      aluSub,
      aluSll,
      aluSlt,                                     // Signed compare
      aluSltu,                                    // Unsigned compare
      aluXor,
      aluSrl,
      aluSra,
      aluOr,
      aluAnd
   } aluOpT;

   typedef enum logic [1:0] {
      srcARs1,                                    // Register rs1
      srcAPc,                                     // For auipc
      srcAZero                                    // For lui
   } srcAT;

   typedef enum logic {
      srcBRs2,
      srcBImm
   } srcBT;

   // funct3 codes
   localparam logic [2:0] f3AddSub = 3'b000;
   localparam logic [2:0] f3Sll    = 3'b001;
   localparam logic [2:0] f3Slt    = 3'b010;
   localparam logic [2:0] f3Sltu   = 3'b011;
   localparam logic [2:0] f3Xor    = 3'b100;
   localparam logic [2:0] f3SrlSra = 3'b101;
   localparam logic [2:0] f3Or     = 3'b110;
   localparam logic [2:0] f3And    = 3'b111;
   localparam logic [2:0] f3Sw     = 3'b010;      // Store word width code

   // funct7 codes
   localparam logic [6:0] f7Base = 7'b0000000;    // add, srl
   localparam logic [6:0] f7Alt  = 7'b0100000;    // sub, sra

   localparam logic [xlen-1:0] nopWord = 32'h0000_0013;  // addi x0,x0,0

endpackage
